//--- dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// CPU address and data path
`define DC_ADDR_WIDTH      32
`define DC_DATA_WIDTH      32
// One select bit per byte lane
`define DC_BSEL_WIDTH      (`DC_DATA_WIDTH / 8)

// Cache geometry, 16 byte lines in 16 sets of 2 ways
`define DC_BLOCK_WIDTH     4
`define DC_SET_WIDTH       4
`define DC_WAYS            2
`define DC_WORD_SEL_WIDTH  2
`define DC_TAG_WIDTH       (`DC_ADDR_WIDTH - `DC_SET_WIDTH - `DC_BLOCK_WIDTH)
`define DC_SETS            (1 << `DC_SET_WIDTH)
// Words held by one way
`define DC_WAY_DEPTH       (1 << (`DC_SET_WIDTH + `DC_WORD_SEL_WIDTH))

// Address field positions
`define DC_WORD_LSB        (`DC_BLOCK_WIDTH - `DC_WORD_SEL_WIDTH)
`define DC_TAG_LSB         (`DC_BLOCK_WIDTH + `DC_SET_WIDTH)

// SPR bus, block invalidate register of the data cache group
`define DC_SPR_ADDR_WIDTH  16
`define DC_SPR_DCBIR_ADDR  16'h1803

`endif

//--- dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

   // Address and data fields
   typedef logic [`DC_DATA_WIDTH-1:0]     word_t;
   typedef logic [`DC_TAG_WIDTH-1:0]      tag_t;
   typedef logic [`DC_SET_WIDTH-1:0]      index_t;
   typedef logic [`DC_WORD_SEL_WIDTH-1:0] word_sel_t;
   // One hot, bit n stands for way n
   typedef logic [`DC_WAYS-1:0]           way_vec_t;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL,
      INVALIDATE
   } ctrl_state_e;

   // Tag store update, one per cycle
   typedef enum logic [2:0] {
      TAG_NONE,
      // Accessed way becomes most recently used
      TAG_TOUCH,
      // Victim way loses its valid bit at refill start
      TAG_CLEAR_WAY,
      // Victim way gets the new tag and becomes valid
      TAG_INSTALL,
      // Both ways of the set dropped
      TAG_INVALIDATE
   } tag_cmd_e;

   // Data store write
   typedef enum logic [1:0] {
      DATA_NONE,
      DATA_STORE,
      DATA_REFILL
   } data_cmd_e;

endpackage

//--- dcache_tag_store.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_tag_store (
   input  logic                   clk,
   input  logic                   rst,
   input  dcache_pkg::index_t     rd_index_i,
   input  dcache_pkg::tag_t       cmp_tag_i,
   input  dcache_pkg::index_t     wr_index_i,
   input  dcache_pkg::tag_cmd_e   tag_cmd_i,
   input  dcache_pkg::way_vec_t   victim_way_i,
   output dcache_pkg::way_vec_t   way_hit_o,
   output dcache_pkg::way_vec_t   lru_way_o
);

   // Tag RAM, one bank per way
   dcache_pkg::tag_t tag_ram [`DC_WAYS][`DC_SETS];
   // Registered RAM output
   dcache_pkg::tag_t tag_q [`DC_WAYS];

   // Valid bits per set, in flops
   logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
   // Set means way 1 is least recently used
   logic lru_q [`DC_SETS];

   // Index of the word in tag_q
   dcache_pkg::index_t rd_index_q;
   logic [`DC_WAYS-1:0] set_valid;

   // Synchronous read of both banks every cycle
   always_ff @(posedge clk) begin
      rd_index_q <= rd_index_i;
      for (int w = 0; w < `DC_WAYS; w++) begin
         tag_q[w] <= tag_ram[w][rd_index_i];
      end
   end

   // Only an install writes a tag, and only into the victim bank
   always_ff @(posedge clk) begin
      if (tag_cmd_i == dcache_pkg::TAG_INSTALL) begin
         for (int w = 0; w < `DC_WAYS; w++) begin
            if (victim_way_i[w]) begin
               tag_ram[w][wr_index_i] <= cmp_tag_i;
            end
         end
      end
   end

   // Valid bits follow the tag read index
   assign set_valid = valid_q[rd_index_q];

   // Hit when the way is valid and its tag matches the request
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         way_hit_o[w] = set_valid[w] && (tag_q[w] == cmp_tag_i);
      end
   end

   // Replacement candidate as one hot vector
   assign lru_way_o = lru_q[rd_index_q] ? dcache_pkg::way_vec_t'(2'b10)
                                        : dcache_pkg::way_vec_t'(2'b01);

   // Valid and LRU update
   always_ff @(posedge clk) begin
      if (rst) begin
         // Sweep every set to invalid
         for (int s = 0; s < `DC_SETS; s++) begin
            valid_q[s] <= '0;
            lru_q[s]   <= 1'b0;
         end
      end else begin
         case (tag_cmd_i)
            dcache_pkg::TAG_TOUCH: begin
               // A way 0 hit leaves way 1 as LRU and vice versa
               lru_q[wr_index_i] <= way_hit_o[0];
            end
            dcache_pkg::TAG_CLEAR_WAY: begin
               valid_q[wr_index_i] <= valid_q[wr_index_i] & ~victim_way_i;
            end
            dcache_pkg::TAG_INSTALL: begin
               valid_q[wr_index_i] <= valid_q[wr_index_i] | victim_way_i;
               // Refilled way is now the most recent
               lru_q[wr_index_i]   <= victim_way_i[0];
            end
            dcache_pkg::TAG_INVALIDATE: begin
               valid_q[wr_index_i] <= '0;
               lru_q[wr_index_i]   <= 1'b0;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

//--- dcache_data_store.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_data_store (
   input  logic                                        clk,
   input  logic [`DC_SET_WIDTH+`DC_WORD_SEL_WIDTH-1:0] rd_adr_i,
   input  dcache_pkg::way_vec_t                        way_hit_i,
   input  dcache_pkg::way_vec_t                        victim_way_i,
   input  dcache_pkg::data_cmd_e                       data_cmd_i,
   input  dcache_pkg::word_sel_t                       refill_sel_i,
   input  dcache_pkg::word_t                           cpu_dat_i,
   input  logic [`DC_BSEL_WIDTH-1:0]                   cpu_bsel_i,
   input  dcache_pkg::word_t                           refill_dat_i,
   output dcache_pkg::word_t                           rd_dat_o
);

   // One word RAM per way, addressed by set and word
   dcache_pkg::word_t way_ram [`DC_WAYS][`DC_WAY_DEPTH];
   dcache_pkg::word_t way_q [`DC_WAYS];

   // CPU bytes over the cached word
   dcache_pkg::word_t merge_dat;
   dcache_pkg::word_t wr_dat;
   logic [`DC_SET_WIDTH+`DC_WORD_SEL_WIDTH-1:0] wr_adr;
   dcache_pkg::way_vec_t wr_way;

   // Both ways read every cycle
   always_ff @(posedge clk) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         way_q[w] <= way_ram[w][rd_adr_i];
      end
   end

   // Hitting way drives the read port
   always_comb begin
      rd_dat_o = way_q[0];
      for (int w = 1; w < `DC_WAYS; w++) begin
         if (way_hit_i[w]) begin
            rd_dat_o = way_q[w];
         end
      end
   end

   // Byte merge for a store hit
   always_comb begin
      for (int b = 0; b < `DC_BSEL_WIDTH; b++) begin
         merge_dat[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : rd_dat_o[8*b +: 8];
      end
   end

   // Write way, address and word
   always_comb begin
      wr_adr = rd_adr_i;
      wr_dat = merge_dat;
      wr_way = '0;
      case (data_cmd_i)
         dcache_pkg::DATA_STORE: begin
            wr_way = way_hit_i;
         end
         dcache_pkg::DATA_REFILL: begin
            // Same set as the held request, word from the refill address
            wr_way = victim_way_i;
            wr_adr = {rd_adr_i[`DC_SET_WIDTH+`DC_WORD_SEL_WIDTH-1:`DC_WORD_SEL_WIDTH],
                      refill_sel_i};
            wr_dat = refill_dat_i;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (wr_way[w]) begin
            way_ram[w][wr_adr] <= wr_dat;
         end
      end
   end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ctrl (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           cpu_req_i,
   input  logic                           cpu_we_i,
   input  logic [`DC_ADDR_WIDTH-1:0]      cpu_adr_i,
   input  dcache_pkg::way_vec_t           way_hit_i,
   input  dcache_pkg::way_vec_t           lru_way_i,
   input  logic                           refill_we_i,
   input  logic [`DC_ADDR_WIDTH-1:0]      refill_adr_i,
   input  logic                           spr_bus_stb_i,
   input  logic                           spr_bus_we_i,
   input  logic [`DC_SPR_ADDR_WIDTH-1:0]  spr_bus_addr_i,
   input  dcache_pkg::word_t              spr_bus_dat_i,
   output dcache_pkg::tag_cmd_e           tag_cmd_o,
   output dcache_pkg::data_cmd_e          data_cmd_o,
   output dcache_pkg::way_vec_t           victim_way_o,
   output dcache_pkg::index_t             wr_index_o,
   output dcache_pkg::word_sel_t          refill_sel_o,
   output logic                           cpu_ack_o,
   output logic                           refill_req_o,
   output logic                           spr_bus_ack_o
);

   dcache_pkg::ctrl_state_e state_q;
   dcache_pkg::ctrl_state_e state_d;

   // Set of the held request
   dcache_pkg::index_t cpu_index;
   // Set named by the invalidate write
   dcache_pkg::index_t inv_index_q;
   // Way chosen for replacement at the miss
   dcache_pkg::way_vec_t victim_q;

   logic hit;
   logic inv_req;
   logic refill_first;
   logic refill_last;

   assign cpu_index = cpu_adr_i[`DC_TAG_LSB-1:`DC_BLOCK_WIDTH];
   assign hit       = |way_hit_i;

   // Block invalidate write on the SPR bus
   assign inv_req = spr_bus_stb_i & spr_bus_we_i &
                    (spr_bus_addr_i == `DC_SPR_DCBIR_ADDR);

   // Refill words come in line order, position from the word address
   assign refill_sel_o = refill_adr_i[`DC_BLOCK_WIDTH-1:`DC_WORD_LSB];
   assign refill_first = refill_we_i & (refill_sel_o == '0);
   assign refill_last  = refill_we_i & (refill_sel_o == '1);

   assign victim_way_o = victim_q;

   always_comb begin
      state_d       = state_q;
      tag_cmd_o     = dcache_pkg::TAG_NONE;
      data_cmd_o    = dcache_pkg::DATA_NONE;
      wr_index_o    = cpu_index;
      cpu_ack_o     = 1'b0;
      refill_req_o  = 1'b0;
      spr_bus_ack_o = 1'b0;
      case (state_q)
         dcache_pkg::IDLE: begin
            // Invalidate takes priority over the CPU
            if (inv_req) begin
               state_d = dcache_pkg::INVALIDATE;
            end else if (cpu_req_i) begin
               state_d = dcache_pkg::LOOKUP;
            end
         end
         dcache_pkg::LOOKUP: begin
            if (cpu_we_i || hit) begin
               // Any hit, or a write miss which leaves the cache alone
               cpu_ack_o = 1'b1;
               state_d   = dcache_pkg::IDLE;
               if (hit) begin
                  tag_cmd_o = dcache_pkg::TAG_TOUCH;
               end
               if (hit && cpu_we_i) begin
                  data_cmd_o = dcache_pkg::DATA_STORE;
               end
            end else begin
               // Read miss, ask memory for the line
               refill_req_o = 1'b1;
               state_d      = dcache_pkg::REFILL;
            end
         end
         dcache_pkg::REFILL: begin
            refill_req_o = 1'b1;
            if (refill_we_i) begin
               data_cmd_o = dcache_pkg::DATA_REFILL;
            end
            if (refill_last) begin
               // Line complete, the held request looks up again
               tag_cmd_o = dcache_pkg::TAG_INSTALL;
               state_d   = dcache_pkg::IDLE;
            end else if (refill_first) begin
               // Old line in the victim is gone from here on
               tag_cmd_o = dcache_pkg::TAG_CLEAR_WAY;
            end
         end
         dcache_pkg::INVALIDATE: begin
            spr_bus_ack_o = 1'b1;
            tag_cmd_o     = dcache_pkg::TAG_INVALIDATE;
            wr_index_o    = inv_index_q;
            state_d       = dcache_pkg::IDLE;
         end
         default: begin
            state_d = dcache_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= dcache_pkg::IDLE;
         victim_q <= dcache_pkg::way_vec_t'(2'b01);
      end else begin
         state_q <= state_d;
         // Keep the LRU way seen at the miss for the whole refill
         if (state_q == dcache_pkg::LOOKUP && state_d == dcache_pkg::REFILL) begin
            victim_q <= lru_way_i;
         end
      end
   end

   // Set index from the byte address on the SPR data bus
   always_ff @(posedge clk) begin
      if (state_q == dcache_pkg::IDLE && inv_req) begin
         inv_index_q <= spr_bus_dat_i[`DC_TAG_LSB-1:`DC_BLOCK_WIDTH];
      end
   end

endmodule

//--- dcache_top.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_top (
   input  logic                           clk,
   input  logic                           rst,
   // CPU request, held until ack
   input  logic                           cpu_req_i,
   input  logic                           cpu_we_i,
   input  logic [`DC_ADDR_WIDTH-1:0]      cpu_adr_i,
   input  dcache_pkg::word_t              cpu_dat_i,
   input  logic [`DC_BSEL_WIDTH-1:0]      cpu_bsel_i,
   output dcache_pkg::word_t              cpu_dat_o,
   output logic                           cpu_ack_o,
   // Line refill from memory
   output logic                           refill_req_o,
   input  logic                           refill_we_i,
   input  logic [`DC_ADDR_WIDTH-1:0]      refill_adr_i,
   input  dcache_pkg::word_t              refill_dat_i,
   // SPR block invalidate
   input  logic                           spr_bus_stb_i,
   input  logic                           spr_bus_we_i,
   input  logic [`DC_SPR_ADDR_WIDTH-1:0]  spr_bus_addr_i,
   input  dcache_pkg::word_t              spr_bus_dat_i,
   output logic                           spr_bus_ack_o
);

   // Lookup results from the tag store
   dcache_pkg::way_vec_t  way_hit;
   dcache_pkg::way_vec_t  lru_way;
   // Controller commands to both stores
   dcache_pkg::tag_cmd_e  tag_cmd;
   dcache_pkg::data_cmd_e data_cmd;
   dcache_pkg::way_vec_t  victim_way;
   dcache_pkg::index_t    wr_index;
   dcache_pkg::word_sel_t refill_sel;

   dcache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .way_hit_i      (way_hit),
      .lru_way_i      (lru_way),
      .refill_we_i    (refill_we_i),
      .refill_adr_i   (refill_adr_i),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .tag_cmd_o      (tag_cmd),
      .data_cmd_o     (data_cmd),
      .victim_way_o   (victim_way),
      .wr_index_o     (wr_index),
      .refill_sel_o   (refill_sel),
      .cpu_ack_o      (cpu_ack_o),
      .refill_req_o   (refill_req_o),
      .spr_bus_ack_o  (spr_bus_ack_o)
   );

   // Both stores read at the set of the CPU address
   dcache_tag_store u_tag_store (
      .clk          (clk),
      .rst          (rst),
      .rd_index_i   (cpu_adr_i[`DC_TAG_LSB-1:`DC_BLOCK_WIDTH]),
      .cmp_tag_i    (cpu_adr_i[`DC_ADDR_WIDTH-1:`DC_TAG_LSB]),
      .wr_index_i   (wr_index),
      .tag_cmd_i    (tag_cmd),
      .victim_way_i (victim_way),
      .way_hit_o    (way_hit),
      .lru_way_o    (lru_way)
   );

   dcache_data_store u_data_store (
      .clk          (clk),
      .rd_adr_i     (cpu_adr_i[`DC_TAG_LSB-1:`DC_WORD_LSB]),
      .way_hit_i    (way_hit),
      .victim_way_i (victim_way),
      .data_cmd_i   (data_cmd),
      .refill_sel_i (refill_sel),
      .cpu_dat_i    (cpu_dat_i),
      .cpu_bsel_i   (cpu_bsel_i),
      .refill_dat_i (refill_dat_i),
      .rd_dat_o     (cpu_dat_o)
   );

endmodule

//--- dcache_assert.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_assert (
   input logic                      clk,
   input logic                      rst,
   input logic                      cpu_ack_o,
   input logic                      spr_bus_ack_o,
   input logic                      refill_req_o,
   input logic                      refill_we_i,
   input logic [`DC_ADDR_WIDTH-1:0] refill_adr_i
);

   // Number of failed assertions so far
   int fail_count = 0;
   // Word 3 of the line delivered in this cycle
   logic last_word;

   assign last_word = refill_we_i &&
                      (refill_adr_i[`DC_BLOCK_WIDTH-1:`DC_WORD_LSB] == '1);

   // Acks are single cycle pulses
   cpu_ack_pulse: assert property (@(posedge clk) disable iff (rst)
      cpu_ack_o |=> !cpu_ack_o)
   else begin
      fail_count++;
      $error("cpu_ack_o high for two cycles");
   end

   spr_ack_pulse: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_o |=> !spr_bus_ack_o)
   else begin
      fail_count++;
      $error("spr_bus_ack_o high for two cycles");
   end

   // No CPU ack while a line is still coming in
   ack_during_refill: assert property (@(posedge clk) disable iff (rst)
      !(cpu_ack_o && refill_req_o))
   else begin
      fail_count++;
      $error("cpu_ack_o during refill_req_o");
   end

   // Refill request held until the last word
   refill_req_held: assert property (@(posedge clk) disable iff (rst)
      (refill_req_o && !last_word) |=> refill_req_o)
   else begin
      fail_count++;
      $error("refill_req_o dropped before word 3");
   end

endmodule

bind dcache_top dcache_assert u_assert (
   .clk           (clk),
   .rst           (rst),
   .cpu_ack_o     (cpu_ack_o),
   .spr_bus_ack_o (spr_bus_ack_o),
   .refill_req_o  (refill_req_o),
   .refill_we_i   (refill_we_i),
   .refill_adr_i  (refill_adr_i)
);

//--- tb_dcache.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module tb_dcache;

   localparam int          MAX_VECTORS = 64;
   localparam int          TIMEOUT_CYCLES = 200;
   // Memory model content rule, word = address xor pattern
   localparam logic [31:0] MEM_PATTERN = 32'hc0de_0000;

   logic clk;
   logic rst;
   logic cpu_req_i;
   logic cpu_we_i;
   logic [`DC_ADDR_WIDTH-1:0] cpu_adr_i;
   dcache_pkg::word_t cpu_dat_i;
   logic [`DC_BSEL_WIDTH-1:0] cpu_bsel_i;
   dcache_pkg::word_t cpu_dat_o;
   logic cpu_ack_o;
   logic refill_req_o;
   logic refill_we_i;
   logic [`DC_ADDR_WIDTH-1:0] refill_adr_i;
   dcache_pkg::word_t refill_dat_i;
   logic spr_bus_stb_i;
   logic spr_bus_we_i;
   logic [`DC_SPR_ADDR_WIDTH-1:0] spr_bus_addr_i;
   dcache_pkg::word_t spr_bus_dat_i;
   logic spr_bus_ack_o;

   // Six words per vector, see the vectors file
   logic [31:0] vectors [0:6*MAX_VECTORS-1];
   logic [31:0] lcg_state = 32'd2;
   int check_count = 0;
   int error_count = 0;
   logic timed_out = 1'b0;

   dcache_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
      end
   endtask

   // Memory model, delivers words 0 to 3 of the line with random gaps
   task automatic serve_refill(input logic [31:0] adr);
      logic [31:0] word_adr;
      int gap;
      for (int w = 0; w < 4; w++) begin
         // First word needs the cache to reach REFILL
         gap = (w == 0) ? 1 + next_random() % 3 : next_random() % 3;
         repeat (gap) @(negedge clk);
         word_adr     = {adr[31:`DC_BLOCK_WIDTH], 4'h0} + 4 * w;
         refill_we_i  = 1'b1;
         refill_adr_i = word_adr;
         refill_dat_i = word_adr ^ MEM_PATTERN;
         @(negedge clk);
         refill_we_i  = 1'b0;
      end
   endtask

   // CPU access, held until ack, serving any refill on the way
   task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] bsel, output int edges,
                             output logic saw_refill, output logic acked,
                             output logic [31:0] rdata);
      int cycles;
      cycles     = 0;
      acked      = 1'b0;
      saw_refill = 1'b0;
      rdata      = '0;
      cpu_req_i  = 1'b1;
      cpu_we_i   = we;
      cpu_adr_i  = adr;
      cpu_dat_i  = dat;
      cpu_bsel_i = bsel;
      while (!acked && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (cpu_ack_o) begin
            acked = 1'b1;
            rdata = cpu_dat_o;
         end else if (refill_req_o) begin
            saw_refill = 1'b1;
            serve_refill(adr);
         end
      end
      cpu_req_i = 1'b0;
      // Count includes the edge that samples the ack
      edges = cycles + 1;
      if (!acked) begin
         $display("Timeout at %0t ns: no ack from cache for address %h", $time, adr);
         error_count++;
         timed_out = 1'b1;
      end
   endtask

   task automatic block_invalidate(input logic [31:0] adr, output int edges,
                                   output logic acked);
      int cycles;
      cycles         = 0;
      acked          = 1'b0;
      spr_bus_stb_i  = 1'b1;
      spr_bus_we_i   = 1'b1;
      spr_bus_addr_i = `DC_SPR_DCBIR_ADDR;
      spr_bus_dat_i  = adr;
      while (!acked && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         acked = spr_bus_ack_o;
      end
      spr_bus_stb_i = 1'b0;
      spr_bus_we_i  = 1'b0;
      edges = cycles + 1;
      if (!acked) begin
         $display("Timeout at %0t ns: no ack for block invalidate of %h", $time, adr);
         error_count++;
         timed_out = 1'b1;
      end
   endtask

   initial begin
      int idx;
      int errors_before;
      int edges;
      int total_errors;
      logic saw_refill;
      logic acked;
      logic [31:0] rdata;
      logic [31:0] op;
      logic [31:0] adr;
      cpu_req_i      = 1'b0;
      cpu_we_i       = 1'b0;
      cpu_adr_i      = '0;
      cpu_dat_i      = '0;
      cpu_bsel_i     = '0;
      refill_we_i    = 1'b0;
      refill_adr_i   = '0;
      refill_dat_i   = '0;
      spr_bus_stb_i  = 1'b0;
      spr_bus_we_i   = 1'b0;
      spr_bus_addr_i = '0;
      spr_bus_dat_i  = '0;
      rst            = 1'b1;
      $readmemh("dcache_vectors.txt", vectors);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      idx = 0;
      while (!timed_out && idx < MAX_VECTORS && vectors[6*idx] !== 32'hf) begin
         @(negedge clk);
         errors_before = error_count;
         op  = vectors[6*idx];
         adr = vectors[6*idx+1];
         if (op == 0 || op == 1) begin
            cpu_access(op[0], adr, vectors[6*idx+2], vectors[6*idx+3][3:0],
                       edges, saw_refill, acked, rdata);
            if (acked) begin
               compare_value("refill_req_o seen", saw_refill, vectors[6*idx+5]);
               // Hits and write misses have a fixed latency
               if (vectors[6*idx+5] == 0) begin
                  compare_value("cpu_ack_o latency", edges, 2);
               end
               if (op == 0) begin
                  compare_value("cpu_dat_o", rdata, vectors[6*idx+4]);
               end
            end
         end else if (op == 2) begin
            block_invalidate(adr, edges, acked);
            if (acked) begin
               compare_value("spr_bus_ack_o latency", edges, 2);
            end
         end else begin
            $display("Vector %0d has an unknown operation %h", idx, op);
            error_count++;
         end
         $display("vector %0d op %0h address %h: %s", idx, op, adr,
                  (error_count == errors_before) ? "ok" : "error");
         idx++;
      end
      if (idx == 0) begin
         $display("No vectors were loaded from dcache_vectors.txt");
         error_count++;
      end
      total_errors = error_count + DUT.u_assert.fail_count;
      $display("%0d vectors, %0d checks, %0d errors, %0d assertion failures",
               idx, check_count, error_count, DUT.u_assert.fail_count);
      if (total_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- dcache_vectors.txt
// columns: op address write_data byte_select expected_read_data expected_refill
// op 0 read, 1 write, 2 block invalidate (address gives the set), f ends the list
// every refill word from memory is its byte address xor c0de0000
0 00001030 00000000 0 c0de1030 1
0 00001034 00000000 0 c0de1034 0
1 00001038 11223344 3 00000000 0
0 00001038 00000000 0 c0de3344 0
1 00002034 deadbeef f 00000000 0
0 00002034 00000000 0 c0de2034 1
0 00001030 00000000 0 c0de1030 0
0 00003030 00000000 0 c0de3030 1
0 0000103c 00000000 0 c0de103c 0
0 00002030 00000000 0 c0de2030 1
0 00001038 00000000 0 c0de3344 0
2 00000030 00000000 0 00000000 0
0 00001038 00000000 0 c0de1038 1
0 00002030 00000000 0 c0de2030 1
f 00000000 00000000 0 00000000 0

//--- all.f
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_top.sv
dcache_assert.sv
tb_dcache.sv
